//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ====================
	// Widths
	// ====================
	localparam int data_width = 16;
	localparam int addr_width = 8;
	localparam int reg_count = 8;
	localparam int reg_sel_width = 3;
	localparam int flag_width = 3;

	// Bit positions in the flags word.
	localparam int flag_idx_zero = 0;
	localparam int flag_idx_neg = 1;
	localparam int flag_idx_carry = 2;

	// ====================
	// Instruction fields
	// ====================
	localparam int type_hi = 15;
	localparam int type_lo = 13;
	localparam int op_hi = 12;
	localparam int op_lo = 8;
	localparam int rd_hi = 7;
	localparam int rd_lo = 5;
	localparam int rs_hi = 4;
	localparam int rs_lo = 2;
	localparam int imm_hi = 4;
	localparam int imm_lo = 0;
	localparam int off_hi = 7;	// Branch offset, signed, from PC plus one.
	localparam int off_lo = 0;

	// Positions inside the op field.
	localparam int cond_hi = 4;
	localparam int cond_lo = 2;
	localparam int store_bit = 4;

	typedef enum logic [2:0] {
		type_branch = 3'b000,
		type_alu_reg = 3'b001,
		type_alu_imm = 3'b010,
		type_mem = 3'b100,
		type_halt = 3'b111
	} instr_type_t;

	typedef enum logic [4:0] {
		op_add = 5'h00,
		op_sub = 5'h01,
		op_and = 5'h02,
		op_or = 5'h03,
		op_xor = 5'h04,
		op_shl = 5'h05,
		op_shr = 5'h06,
		op_mov = 5'h07,
		op_cmp = 5'h08		// Subtract, flags only.
	} alu_op_t;

	typedef enum logic [2:0] {
		cond_never = 3'b000,
		cond_zero = 3'b001,
		cond_not_zero = 3'b010,
		cond_neg = 3'b011,
		cond_carry = 3'b100,
		cond_always = 3'b111
	} cond_t;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_writeback,
		st_halt
	} cpu_state_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc
	} wb_sel_t;

endpackage

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  logic [cpu_pkg::data_width-1:0]      a,
	input  logic [cpu_pkg::data_width-1:0]      b,
	input  cpu_pkg::alu_op_t                    alu_op,
	output logic [cpu_pkg::data_width-1:0]      result,
	output logic [cpu_pkg::flag_width-1:0]      flags_out
);

	logic [cpu_pkg::data_width:0] wide;	// Top bit is the carry.

	always_comb begin
		case (alu_op)
			cpu_pkg::op_add:
				wide = {1'b0, a} + {1'b0, b};
			cpu_pkg::op_sub, cpu_pkg::op_cmp:
				wide = {1'b0, a} + {1'b0, ~b} + 1'b1;	// Carry means no borrow.
			cpu_pkg::op_and:
				wide = {1'b0, a & b};
			cpu_pkg::op_or:
				wide = {1'b0, a | b};
			cpu_pkg::op_xor:
				wide = {1'b0, a ^ b};
			cpu_pkg::op_shl:
				wide = {1'b0, a << b[3:0]};
			cpu_pkg::op_shr:
				wide = {1'b0, a >> b[3:0]};
			cpu_pkg::op_mov:
				wide = {1'b0, b};
			default:
				wide = '0;
		endcase
	end

	assign result = wide[cpu_pkg::data_width-1:0];

	always_comb begin
		flags_out = '0;
		flags_out[cpu_pkg::flag_idx_zero] = result == '0;
		flags_out[cpu_pkg::flag_idx_neg] = result[cpu_pkg::data_width-1];
		flags_out[cpu_pkg::flag_idx_carry] = wide[cpu_pkg::data_width];
	end

endmodule

`default_nettype wire

//--- hw/register_bank.sv
`timescale 1ns/100ps
`default_nettype none

module register_bank (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic [cpu_pkg::reg_sel_width-1:0]   rd_sel,
	input  logic [cpu_pkg::reg_sel_width-1:0]   rs_sel,
	input  logic                                reg_write,
	input  logic [cpu_pkg::data_width-1:0]      wdata,
	input  logic [cpu_pkg::flag_width-1:0]      flag_write_mask,
	input  logic [cpu_pkg::flag_width-1:0]      flags_in,
	output logic [cpu_pkg::data_width-1:0]      rd_data,
	output logic [cpu_pkg::data_width-1:0]      rs_data,
	output logic [cpu_pkg::flag_width-1:0]      flags
);

	logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++)
				regs[i] <= '0;
			flags <= '0;
		end else begin
			if (reg_write)
				regs[rd_sel] <= wdata;
			flags <= (flags & ~flag_write_mask) | (flags_in & flag_write_mask);
		end
	end

	assign rd_data = regs[rd_sel];
	assign rs_data = regs[rs_sel];

endmodule

`default_nettype wire

//--- hw/cpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic [cpu_pkg::data_width-1:0]      cpu_rdata,
	input  logic                                ir_load,
	input  logic                                pc_write,
	input  logic                                pc_sel_branch,
	input  logic                                reg_write,
	input  logic [cpu_pkg::flag_width-1:0]      flag_write_mask,
	input  cpu_pkg::alu_op_t                    alu_op,
	input  cpu_pkg::cond_t                      cond,
	input  logic                                sel_imm,
	input  logic                                sign_ext,
	input  cpu_pkg::wb_sel_t                    wb_sel,
	output cpu_pkg::instr_type_t                instr_type,
	output logic [4:0]                          op,
	output logic                                cond_true,
	output logic [cpu_pkg::addr_width-1:0]      pc,
	output logic [cpu_pkg::addr_width-1:0]      data_addr,
	output logic [cpu_pkg::data_width-1:0]      data_wdata
);

	localparam int imm_width = cpu_pkg::imm_hi - cpu_pkg::imm_lo + 1;

	logic [cpu_pkg::data_width-1:0] ir, instr_word;
	logic [cpu_pkg::data_width-1:0] rd_data, rs_data, imm_ext, alu_b, alu_result, wb_data;
	logic [imm_width-1:0] imm;
	logic [cpu_pkg::addr_width-1:0] pc_next, branch_target;
	logic [cpu_pkg::flag_width-1:0] flags, alu_flags;

	always_ff @(posedge CLK) begin
		if (reset) begin
			ir <= '0;
			pc <= '0;
		end else begin
			if (ir_load)
				ir <= cpu_rdata;
			if (pc_write)
				pc <= pc_sel_branch ? branch_target : pc_next;
		end
	end

	// The decode cycle sees the fetched word before the IR holds it.
	assign instr_word = ir_load ? cpu_rdata : ir;
	assign instr_type = cpu_pkg::instr_type_t'(instr_word[cpu_pkg::type_hi:cpu_pkg::type_lo]);
	assign op = instr_word[cpu_pkg::op_hi:cpu_pkg::op_lo];

	assign pc_next = pc + 1'b1;
	assign branch_target = pc_next + ir[cpu_pkg::off_hi:cpu_pkg::off_lo];	// Wraps mod 256.

	// ====================
	// Operands
	// ====================
	assign imm = ir[cpu_pkg::imm_hi:cpu_pkg::imm_lo];
	assign imm_ext = {{(cpu_pkg::data_width - imm_width){sign_ext & imm[imm_width-1]}}, imm};
	assign alu_b = sel_imm ? imm_ext : rs_data;

	always_comb begin
		case (wb_sel)
			cpu_pkg::wb_mem: wb_data = cpu_rdata;
			default:         wb_data = alu_result;
		endcase
	end

	always_comb begin
		case (cond)
			cpu_pkg::cond_zero:     cond_true = flags[cpu_pkg::flag_idx_zero];
			cpu_pkg::cond_not_zero: cond_true = ~flags[cpu_pkg::flag_idx_zero];
			cpu_pkg::cond_neg:      cond_true = flags[cpu_pkg::flag_idx_neg];
			cpu_pkg::cond_carry:    cond_true = flags[cpu_pkg::flag_idx_carry];
			cpu_pkg::cond_always:   cond_true = 1'b1;
			default:                cond_true = 1'b0;
		endcase
	end

	// Rs holds the address, rd the store data.
	assign data_addr = rs_data[cpu_pkg::addr_width-1:0];
	assign data_wdata = rd_data;

	register_bank register_bank_i (
		.CLK             (CLK),
		.reset           (reset),
		.rd_sel          (ir[cpu_pkg::rd_hi:cpu_pkg::rd_lo]),
		.rs_sel          (ir[cpu_pkg::rs_hi:cpu_pkg::rs_lo]),
		.reg_write       (reg_write),
		.wdata           (wb_data),
		.flag_write_mask (flag_write_mask),
		.flags_in        (alu_flags),
		.rd_data         (rd_data),
		.rs_data         (rs_data),
		.flags           (flags)
	);

	alu alu_i (
		.a         (rd_data),
		.b         (alu_b),
		.alu_op    (alu_op),
		.result    (alu_result),
		.flags_out (alu_flags)
	);

endmodule

`default_nettype wire

//--- hw/cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic                                run,
	input  cpu_pkg::instr_type_t                instr_type,
	input  logic [4:0]                          op,
	input  logic                                cond_true,
	input  logic                                fetch_gnt,
	input  logic                                data_gnt,
	output logic                                fetch_req,
	output logic                                data_req,
	output logic                                mem_we,
	output logic                                ir_load,
	output logic                                pc_write,
	output logic                                pc_sel_branch,
	output logic                                reg_write,
	output logic [cpu_pkg::flag_width-1:0]      flag_write_mask,
	output cpu_pkg::alu_op_t                    alu_op,
	output cpu_pkg::cond_t                      cond,
	output logic                                sel_imm,
	output logic                                sign_ext,
	output cpu_pkg::wb_sel_t                    wb_sel,
	output logic                                halted
);

	cpu_pkg::cpu_state_t state;
	cpu_pkg::alu_op_t dec_op;
	logic dec_reg_write;
	logic [cpu_pkg::flag_width-1:0] dec_flag_mask;
	logic load_wait;
	logic exec_done;

	assign dec_op = cpu_pkg::alu_op_t'(op);

	// Arithmetic ops set all flags, logic ops and moves only zero and negative.
	function automatic logic [cpu_pkg::flag_width-1:0] flag_mask(cpu_pkg::alu_op_t f_op);
		logic [cpu_pkg::flag_width-1:0] m;
		m = '0;
		if (f_op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_cmp}) begin
			m[cpu_pkg::flag_idx_carry] = 1'b1;
		end
		if (f_op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_cmp, cpu_pkg::op_and,
				cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_shl, cpu_pkg::op_shr,
				cpu_pkg::op_mov}) begin
			m[cpu_pkg::flag_idx_zero] = 1'b1;
			m[cpu_pkg::flag_idx_neg] = 1'b1;
		end
		return m;
	endfunction

	// Execute is over after one cycle, or after the memory access for mem types.
	always_comb begin
		exec_done = 1'b0;
		if (state == cpu_pkg::st_execute) begin
			if (instr_type == cpu_pkg::type_mem)
				exec_done = load_wait || (data_gnt && mem_we);
			else
				exec_done = instr_type != cpu_pkg::type_halt;
		end
	end

	// ====================
	// Instruction cycle
	// ====================
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= cpu_pkg::st_fetch;
			fetch_req <= 1'b0;
			data_req <= 1'b0;
			mem_we <= 1'b0;
			ir_load <= 1'b0;
			pc_write <= 1'b0;
			pc_sel_branch <= 1'b0;
			reg_write <= 1'b0;
			flag_write_mask <= '0;
			alu_op <= cpu_pkg::op_add;
			cond <= cpu_pkg::cond_never;
			sel_imm <= 1'b0;
			sign_ext <= 1'b0;
			wb_sel <= cpu_pkg::wb_alu;
			halted <= 1'b0;
			dec_reg_write <= 1'b0;
			dec_flag_mask <= '0;
			load_wait <= 1'b0;
		end else begin
			case (state)
				cpu_pkg::st_fetch: begin
					if (fetch_gnt) begin
						fetch_req <= 1'b0;
						ir_load <= 1'b1;	// IR captures the word next cycle.
						state <= cpu_pkg::st_decode;
					end else begin
						fetch_req <= fetch_req | run;
					end
				end
				cpu_pkg::st_decode: begin
					ir_load <= 1'b0;
					alu_op <= dec_op;
					cond <= cpu_pkg::cond_never;
					sel_imm <= 1'b0;
					sign_ext <= 1'b0;
					wb_sel <= cpu_pkg::wb_alu;
					dec_reg_write <= 1'b0;
					dec_flag_mask <= '0;
					case (instr_type)
						cpu_pkg::type_alu_reg, cpu_pkg::type_alu_imm: begin
							sel_imm <= instr_type == cpu_pkg::type_alu_imm;
							sign_ext <= dec_op inside {cpu_pkg::op_add, cpu_pkg::op_sub,
									cpu_pkg::op_cmp, cpu_pkg::op_mov};
							dec_reg_write <= dec_op != cpu_pkg::op_cmp;
							dec_flag_mask <= flag_mask(dec_op);
						end
						cpu_pkg::type_mem: begin
							wb_sel <= cpu_pkg::wb_mem;
							dec_reg_write <= ~op[cpu_pkg::store_bit];
							mem_we <= op[cpu_pkg::store_bit];
							data_req <= 1'b1;
						end
						cpu_pkg::type_branch:
							cond <= cpu_pkg::cond_t'(op[cpu_pkg::cond_hi:cpu_pkg::cond_lo]);
						default: ;	// Halt needs no decode.
					endcase
					state <= cpu_pkg::st_execute;
				end
				cpu_pkg::st_execute: begin
					if (data_gnt) begin
						data_req <= 1'b0;
						mem_we <= 1'b0;
						load_wait <= ~mem_we;	// Read word arrives next cycle.
					end
					if (exec_done) begin
						load_wait <= 1'b0;
						reg_write <= dec_reg_write;
						flag_write_mask <= dec_flag_mask;
						pc_write <= 1'b1;
						pc_sel_branch <= (instr_type == cpu_pkg::type_branch) && cond_true;
						state <= cpu_pkg::st_writeback;
					end else if (instr_type == cpu_pkg::type_halt) begin
						halted <= 1'b1;
						state <= cpu_pkg::st_halt;
					end
				end
				cpu_pkg::st_writeback: begin
					reg_write <= 1'b0;
					flag_write_mask <= '0;
					pc_write <= 1'b0;
					pc_sel_branch <= 1'b0;
					fetch_req <= run;
					state <= cpu_pkg::st_fetch;
				end
				cpu_pkg::st_halt: halted <= 1'b1;	// Left only by reset.
				default: state <= cpu_pkg::st_fetch;
			endcase
		end
	end

	// A store and a register write never overlap.
	assert property (@(posedge CLK) disable iff (reset) !(mem_we && reg_write));

	assert property (@(posedge CLK) disable iff (reset)
		data_req |-> state == cpu_pkg::st_execute);

endmodule

`default_nettype wire

//--- hw/arbitrated_memory.sv
`timescale 1ns/100ps
`default_nettype none

module arbitrated_memory (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic                                host_req,
	input  logic                                host_we,
	input  logic [cpu_pkg::addr_width-1:0]      host_addr,
	input  logic [cpu_pkg::data_width-1:0]      host_wdata,
	input  logic                                fetch_req,
	input  logic [cpu_pkg::addr_width-1:0]      fetch_addr,
	input  logic                                data_req,
	input  logic                                data_we,
	input  logic [cpu_pkg::addr_width-1:0]      data_addr,
	input  logic [cpu_pkg::data_width-1:0]      data_wdata,
	output logic                                host_gnt,
	output logic                                fetch_gnt,
	output logic                                data_gnt,
	output logic [cpu_pkg::data_width-1:0]      host_rdata,
	output logic [cpu_pkg::data_width-1:0]      cpu_rdata
);

	logic [cpu_pkg::data_width-1:0] mem [2**cpu_pkg::addr_width];
	logic [cpu_pkg::addr_width-1:0] acc_addr;
	logic [cpu_pkg::data_width-1:0] acc_wdata;
	logic acc_we;

	// Host first, then data, then fetch.
	assign host_gnt = host_req;
	assign data_gnt = data_req & ~host_req;
	assign fetch_gnt = fetch_req & ~host_req & ~data_req;

	always_comb begin
		acc_addr = fetch_addr;
		acc_wdata = data_wdata;
		acc_we = 1'b0;
		if (host_gnt) begin
			acc_addr = host_addr;
			acc_wdata = host_wdata;
			acc_we = host_we;
		end else if (data_gnt) begin
			acc_addr = data_addr;
			acc_we = data_we;
		end
	end

	always_ff @(posedge CLK) begin
		if (acc_we)
			mem[acc_addr] <= acc_wdata;
		if (host_gnt && !host_we)
			host_rdata <= mem[acc_addr];
		if ((data_gnt && !data_we) || fetch_gnt)
			cpu_rdata <= mem[acc_addr];
	end

	assert property (@(posedge CLK) disable iff (reset)
		$onehot0({host_gnt, data_gnt, fetch_gnt}));

	// The CPU holds each request until it is served.
	assert property (@(posedge CLK) disable iff (reset) (fetch_req && !fetch_gnt) |=> fetch_req);
	assert property (@(posedge CLK) disable iff (reset) (data_req && !data_gnt) |=> data_req);

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic                                run,
	input  logic                                host_req,
	input  logic                                host_we,
	input  logic [cpu_pkg::addr_width-1:0]      host_addr,
	input  logic [cpu_pkg::data_width-1:0]      host_wdata,
	output logic                                host_gnt,
	output logic [cpu_pkg::data_width-1:0]      host_rdata,
	output logic                                halted
);

	cpu_pkg::instr_type_t instr_type;
	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::cond_t cond;
	cpu_pkg::wb_sel_t wb_sel;
	logic [4:0] op;
	logic cond_true, fetch_req, fetch_gnt, data_req, data_gnt, mem_we;
	logic ir_load, pc_write, pc_sel_branch, reg_write, sel_imm, sign_ext;
	logic [cpu_pkg::flag_width-1:0] flag_write_mask;
	logic [cpu_pkg::addr_width-1:0] pc, data_addr;
	logic [cpu_pkg::data_width-1:0] data_wdata, cpu_rdata;

	cpu_control cpu_control_i (
		.CLK             (CLK),
		.reset           (reset),
		.run             (run),
		.instr_type      (instr_type),
		.op              (op),
		.cond_true       (cond_true),
		.fetch_gnt       (fetch_gnt),
		.data_gnt        (data_gnt),
		.fetch_req       (fetch_req),
		.data_req        (data_req),
		.mem_we          (mem_we),
		.ir_load         (ir_load),
		.pc_write        (pc_write),
		.pc_sel_branch   (pc_sel_branch),
		.reg_write       (reg_write),
		.flag_write_mask (flag_write_mask),
		.alu_op          (alu_op),
		.cond            (cond),
		.sel_imm         (sel_imm),
		.sign_ext        (sign_ext),
		.wb_sel          (wb_sel),
		.halted          (halted)
	);

	cpu_datapath cpu_datapath_i (
		.CLK             (CLK),
		.reset           (reset),
		.cpu_rdata       (cpu_rdata),
		.ir_load         (ir_load),
		.pc_write        (pc_write),
		.pc_sel_branch   (pc_sel_branch),
		.reg_write       (reg_write),
		.flag_write_mask (flag_write_mask),
		.alu_op          (alu_op),
		.cond            (cond),
		.sel_imm         (sel_imm),
		.sign_ext        (sign_ext),
		.wb_sel          (wb_sel),
		.instr_type      (instr_type),
		.op              (op),
		.cond_true       (cond_true),
		.pc              (pc),
		.data_addr       (data_addr),
		.data_wdata      (data_wdata)
	);

	arbitrated_memory arbitrated_memory_i (
		.CLK        (CLK),
		.reset      (reset),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.fetch_req  (fetch_req),
		.fetch_addr (pc),
		.data_req   (data_req),
		.data_we    (mem_we),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.host_gnt   (host_gnt),
		.fetch_gnt  (fetch_gnt),
		.data_gnt   (data_gnt),
		.host_rdata (host_rdata),
		.cpu_rdata  (cpu_rdata)
	);

endmodule

`default_nettype wire

//--- verif/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

	logic CLK;
	logic reset;
	logic run;
	logic host_req;
	logic host_we;
	logic [cpu_pkg::addr_width-1:0] host_addr;
	logic [cpu_pkg::data_width-1:0] host_wdata;
	logic host_gnt;
	logic [cpu_pkg::data_width-1:0] host_rdata;
	logic halted;

	int errors;
	logic [15:0] prog [$];

	cpu_top dut_i (
		.CLK        (CLK),
		.reset      (reset),
		.run        (run),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_gnt   (host_gnt),
		.host_rdata (host_rdata),
		.halted     (halted)
	);

	always #10 CLK = ~CLK;

	// Only reset leaves the halt state.
	assert property (@(posedge CLK) disable iff (reset) halted |=> halted)
	else begin
		errors++;
		$display("CHECK FAILED at %0t: halted expected 1, got %b", $time, halted);
	end

	// ====================
	// Encoding and model
	// ====================
	function automatic logic [15:0] alu_rr(input logic [4:0] op, input int rd, input int rs);
		return {cpu_pkg::type_alu_reg, op, 3'(rd), 3'(rs), 2'b00};
	endfunction

	function automatic logic [15:0] alu_ri(input logic [4:0] op, input int rd, input int imm);
		return {cpu_pkg::type_alu_imm, op, 3'(rd), 5'(imm)};
	endfunction

	function automatic logic [15:0] load_instr(input int rd, input int rs);
		return {cpu_pkg::type_mem, 1'b0, 4'h0, 3'(rd), 3'(rs), 2'b00};
	endfunction

	function automatic logic [15:0] store_instr(input int rd, input int rs);
		return {cpu_pkg::type_mem, 1'b1, 4'h0, 3'(rd), 3'(rs), 2'b00};
	endfunction

	function automatic logic [15:0] branch_instr(input logic [2:0] cond, input int offset);
		return {cpu_pkg::type_branch, cond, 2'b00, 8'(offset)};	// Offset from PC plus one.
	endfunction

	function automatic logic [15:0] halt_instr();
		return {cpu_pkg::type_halt, 13'h0};
	endfunction

	// Carry on top of the result.
	function automatic logic [16:0] alu_model(input logic [4:0] op, input logic [15:0] a,
			input logic [15:0] b);
		case (op)
			cpu_pkg::op_add: return {1'b0, a} + {1'b0, b};
			cpu_pkg::op_sub, cpu_pkg::op_cmp: return {a >= b, a - b};	// No borrow sets carry.
			cpu_pkg::op_and: return {1'b0, a & b};
			cpu_pkg::op_or:  return {1'b0, a | b};
			cpu_pkg::op_xor: return {1'b0, a ^ b};
			cpu_pkg::op_shl: return {1'b0, a << b[3:0]};
			cpu_pkg::op_shr: return {1'b0, a >> b[3:0]};
			cpu_pkg::op_mov: return {1'b0, b};
			default: return 17'h0;
		endcase
	endfunction

	function automatic logic [15:0] fill_word(input logic [7:0] addr);
		return {addr, ~addr} ^ 16'h5a3c;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected)
		else begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// ====================
	// Host port
	// ====================
	task automatic host_access(input logic we, input logic [7:0] addr, input logic [15:0] wdata,
			output logic [15:0] rdata);
		int waited;
		@(posedge CLK);
		#2;
		host_req = 1'b1;
		host_we = we;
		host_addr = addr;
		host_wdata = wdata;
		waited = 0;
		@(negedge CLK);
		while (!host_gnt && waited < 20) begin
			waited++;
			@(negedge CLK);
		end
		if (!host_gnt) begin
			errors++;
			$display("Host request to address %02h was never granted", addr);
		end else begin
			assert (waited <= 2)
			else begin
				errors++;
				$display("CHECK FAILED at %0t: host_gnt wait expected <= 2, got %0d",
					$time, waited);
			end
		end
		@(posedge CLK);	// Access edge.
		#2;
		host_req = 1'b0;
		host_we = 1'b0;
		@(negedge CLK);
		rdata = host_rdata;
	endtask

	task automatic host_write(input logic [7:0] addr, input logic [15:0] data);
		logic [15:0] unused;
		host_access(1'b1, addr, data, unused);
	endtask

	task automatic read_and_check(input logic [7:0] addr, input logic [15:0] expected);
		logic [15:0] got;
		host_access(1'b0, addr, 16'h0, got);
		check_value($sformatf("host_rdata (addr %02h)", addr), expected, got);
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < prog.size(); i++)
			host_write(8'(i), prog[i]);
	endtask

	task automatic fill_region(input logic [7:0] base, input int count);
		int i;
		for (i = 0; i < count; i++)
			host_write(base + 8'(i), fill_word(base + 8'(i)));
	endtask

	task automatic apply_reset();
		@(posedge CLK);
		#2;
		run = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge CLK);
		#2;
		reset = 1'b0;
	endtask

	task automatic start_run();
		@(posedge CLK);
		#2;
		run = 1'b1;
	endtask

	task automatic wait_halted(input int limit);
		int cycles;
		cycles = 0;
		while (!halted && cycles < limit) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("CPU did not halt within %0d cycles", limit);
		end
	endtask

	// Reads of the spare region while the CPU runs.
	task automatic host_traffic(input int limit);
		int n;
		int gap;
		logic [7:0] addr;
		n = 0;
		while (!halted && n < limit) begin
			gap = $urandom_range(0, 3);
			repeat (gap) @(posedge CLK);
			addr = 8'he0 + 8'($urandom_range(0, 31));
			read_and_check(addr, fill_word(addr));
			n++;
		end
	endtask

	// ====================
	// Programs
	// ====================
	task automatic alu_program_test();
		logic [4:0] ops [8];
		logic [15:0] a, b;
		logic [15:0] expected [$];
		logic [16:0] cmp;
		int i;
		ops = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
			cpu_pkg::op_xor, cpu_pkg::op_shl, cpu_pkg::op_shr, cpu_pkg::op_mov};
		a = 16'($urandom);
		b = 16'($urandom);
		prog = {};
		prog.push_back(alu_ri(cpu_pkg::op_mov, 7, 1));
		prog.push_back(alu_ri(cpu_pkg::op_shl, 7, 7));	// Operands at 0x80.
		prog.push_back(load_instr(1, 7));
		prog.push_back(alu_ri(cpu_pkg::op_add, 7, 1));
		prog.push_back(load_instr(2, 7));
		prog.push_back(alu_ri(cpu_pkg::op_mov, 6, 5));
		prog.push_back(alu_ri(cpu_pkg::op_shl, 6, 5));	// Results from 0xA0.
		for (i = 0; i < 8; i++) begin
			prog.push_back(alu_rr(cpu_pkg::op_mov, 3, 1));
			prog.push_back(alu_rr(ops[i], 3, 2));
			prog.push_back(store_instr(3, 6));
			prog.push_back(alu_ri(cpu_pkg::op_add, 6, 1));
			expected.push_back(16'(alu_model(ops[i], a, b)));
		end
		prog.push_back(alu_rr(cpu_pkg::op_mov, 3, 1));
		prog.push_back(alu_ri(cpu_pkg::op_add, 3, -3));
		prog.push_back(store_instr(3, 6));
		prog.push_back(alu_ri(cpu_pkg::op_add, 6, 1));
		expected.push_back(16'(alu_model(cpu_pkg::op_add, a, 16'hfffd)));
		// Compare, then a marker from the carry.
		prog.push_back(alu_rr(cpu_pkg::op_cmp, 1, 2));
		prog.push_back(alu_ri(cpu_pkg::op_mov, 3, 1));
		prog.push_back(branch_instr(cpu_pkg::cond_carry, 1));
		prog.push_back(alu_ri(cpu_pkg::op_mov, 3, 0));
		prog.push_back(store_instr(3, 6));
		cmp = alu_model(cpu_pkg::op_cmp, a, b);
		expected.push_back(cmp[16] ? 16'h1 : 16'h0);
		prog.push_back(halt_instr());

		load_program();
		host_write(8'h80, a);
		host_write(8'h81, b);
		fill_region(8'ha0, expected.size());
		fill_region(8'he0, 32);
		start_run();
		fork
			wait_halted(5000);
			host_traffic(2000);
		join
		for (i = 0; i < expected.size(); i++)
			read_and_check(8'ha0 + 8'(i), expected[i]);
	endtask

	task automatic quiet_after_halt();
		logic [15:0] snap [256];
		int i;
		for (i = 0; i < 256; i++)
			host_access(1'b0, 8'(i), 16'h0, snap[i]);
		for (i = 0; i < 50; i++) begin
			@(negedge CLK);
			check_value("halted", 16'h1, 16'(halted));
		end
		for (i = 0; i < 256; i++)
			read_and_check(8'(i), snap[i]);
	endtask

	task automatic branch_program_test();
		logic [2:0] conds [4];
		int xs [4];
		int ys [4];
		int n, lo, hi, mark, i;
		logic [16:0] cmp;
		logic taken;
		logic [15:0] expected [$];
		n = $urandom_range(1, 15);
		lo = $urandom_range(0, 14);
		hi = $urandom_range(lo + 1, 15);
		mark = $urandom_range(0, 7);
		conds = '{cpu_pkg::cond_carry, cpu_pkg::cond_carry, cpu_pkg::cond_neg, cpu_pkg::cond_neg};
		xs = '{hi, lo, lo, hi};
		ys = '{lo, hi, hi, lo};
		prog = {};
		prog.push_back(alu_ri(cpu_pkg::op_mov, 6, 5));
		prog.push_back(alu_ri(cpu_pkg::op_shl, 6, 5));
		prog.push_back(alu_ri(cpu_pkg::op_mov, 1, n));
		prog.push_back(alu_ri(cpu_pkg::op_mov, 2, 0));
		prog.push_back(alu_ri(cpu_pkg::op_add, 2, 1));	// Countdown loop.
		prog.push_back(alu_ri(cpu_pkg::op_sub, 1, 1));
		prog.push_back(branch_instr(cpu_pkg::cond_not_zero, -3));
		prog.push_back(store_instr(2, 6));
		prog.push_back(alu_ri(cpu_pkg::op_add, 6, 1));
		expected.push_back(16'(n));
		for (i = 0; i < 4; i++) begin
			prog.push_back(alu_ri(cpu_pkg::op_mov, 4, mark));
			prog.push_back(alu_ri(cpu_pkg::op_mov, 3, xs[i]));
			prog.push_back(alu_ri(cpu_pkg::op_cmp, 3, ys[i]));
			prog.push_back(branch_instr(conds[i], 1));
			prog.push_back(alu_ri(cpu_pkg::op_mov, 4, mark + 8));
			prog.push_back(store_instr(4, 6));
			prog.push_back(alu_ri(cpu_pkg::op_add, 6, 1));
			cmp = alu_model(cpu_pkg::op_cmp, 16'(xs[i]), 16'(ys[i]));
			taken = (conds[i] == cpu_pkg::cond_carry) ? cmp[16] : cmp[15];
			expected.push_back(taken ? 16'(mark) : 16'(mark + 8));
		end
		prog.push_back(halt_instr());

		load_program();
		fill_region(8'ha0, expected.size());
		start_run();
		wait_halted(3000);
		for (i = 0; i < expected.size(); i++)
			read_and_check(8'ha0 + 8'(i), expected[i]);
	endtask

	task automatic copy_program_test();
		logic [15:0] block [8];
		int i;
		prog = {};
		prog.push_back(alu_ri(cpu_pkg::op_mov, 7, 1));
		prog.push_back(alu_ri(cpu_pkg::op_shl, 7, 7));	// Source 0x80.
		prog.push_back(alu_ri(cpu_pkg::op_mov, 6, 3));
		prog.push_back(alu_ri(cpu_pkg::op_shl, 6, 6));	// Destination 0xC0.
		prog.push_back(alu_ri(cpu_pkg::op_mov, 5, 8));
		prog.push_back(load_instr(1, 7));
		prog.push_back(store_instr(1, 6));
		prog.push_back(alu_ri(cpu_pkg::op_add, 7, 1));
		prog.push_back(alu_ri(cpu_pkg::op_add, 6, 1));
		prog.push_back(alu_ri(cpu_pkg::op_sub, 5, 1));
		prog.push_back(branch_instr(cpu_pkg::cond_not_zero, -6));
		prog.push_back(halt_instr());

		load_program();
		for (i = 0; i < 8; i++) begin
			block[i] = 16'($urandom);
			host_write(8'h80 + 8'(i), block[i]);
			host_write(8'hc0 + 8'(i), ~block[i]);
		end
		start_run();
		wait_halted(3000);
		for (i = 0; i < 8; i++) begin
			read_and_check(8'h80 + 8'(i), block[i]);
			read_and_check(8'hc0 + 8'(i), block[i]);
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		logic [7:0] addr;
		logic [15:0] word;
		void'($urandom(32'hf4d5_68f7));
		CLK = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		errors = 0;
		repeat (2) @(posedge CLK);
		#2;
		reset = 1'b0;

		@(negedge CLK);
		check_value("halted", 16'h0, 16'(halted));
		check_value("host_gnt", 16'h0, 16'(host_gnt));
		addr = 8'($urandom);
		word = 16'($urandom);
		host_write(addr, word);
		read_and_check(addr, word);

		apply_reset();
		alu_program_test();
		quiet_after_halt();

		apply_reset();
		branch_program_test();

		apply_reset();
		copy_program_test();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hw/cpu_pkg.sv
hw/alu.sv
hw/register_bank.sv
hw/cpu_datapath.sv
hw/cpu_control.sv
hw/arbitrated_memory.sv
hw/cpu_top.sv
verif/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - hw/cpu_pkg.sv
  - hw/alu.sv
  - hw/register_bank.sv
  - hw/cpu_datapath.sv
  - hw/cpu_control.sv
  - hw/arbitrated_memory.sv
  - hw/cpu_top.sv
  - target: test
    files:
      - verif/cpu_tb.sv
